/* src/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REGS 32

`define RV_RESET_PC 32'h0000_0000 // First fetch address

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// Retire slots granted to the core out of reset
`define RV_RETIRE_CREDITS 4

`endif

/* src/rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // LUI takes operand B as is
    } alu_op_e;

    // ==============================
    // Stage registers
    // ==============================

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
    } if_id_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] rdata1;
        logic [`RV_XLEN-1:0] rdata2;
        logic [`RV_XLEN-1:0] imm;
        alu_op_e             alu_op;
        logic                use_imm; // Operand B from imm
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] result;
    } ex_wb_t;

    // Retire port and register write path
    typedef struct packed {
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } retire_t;

    typedef struct packed {
        logic                en;
        logic [4:0]          addr;
        logic [`RV_XLEN-1:0] data;
    } rf_write_t;

endpackage

/* src/reg_file.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic [4:0]          raddr1_i,
    input  logic [4:0]          raddr2_i,
    input  rv_pkg::rf_write_t   wr_i,
    output logic [`RV_XLEN-1:0] rdata1_o,
    output logic [`RV_XLEN-1:0] rdata2_o
);

    logic [`RV_XLEN-1:0] regs [1:`RV_REGS-1]; // x0 has no storage

    // Write data bypasses the array on a same-cycle match
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wr_i.en && (wr_i.addr == addr)) begin
            return wr_i.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
    end

    always_comb begin
        rdata2_o = read_port(raddr2_i);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `RV_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.en && (wr_i.addr != 5'd0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Retire logic filters rd = x0 before it reaches the write port
    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        wr_i.en |-> (wr_i.addr != 5'd0));

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                hold_i,
    input  logic [31:0]         inst_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output rv_pkg::if_id_t      if_id_o
);

    logic [`RV_XLEN-1:0] pc_q;

    assign pc_o = pc_q; // Instruction memory answers in the same cycle

    // ==============================
    // Program counter
    // ==============================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (!hold_i) begin
            pc_q <= pc_q + `RV_XLEN'd4; // Straight-line code only
        end
    end

    // ==============================
    // IF/ID register
    // ==============================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_o <= '{valid: 1'b0, pc: `RV_RESET_PC, inst: `RV_NOP};
        end else if (!hold_i) begin
            if_id_o <= '{valid: 1'b1, pc: pc_q, inst: inst_i};
        end
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module decode_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              hold_i,
    input  rv_pkg::if_id_t    if_id_i,
    input  rv_pkg::rf_write_t wr_i,
    output rv_pkg::id_ex_t    id_ex_o
);

    import rv_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0]          opcode;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [2:0]          funct3;
    logic                funct7_5;
    logic                is_op;
    logic                is_op_imm;
    logic                is_lui;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    id_ex_t              id_ex_d;

    // funct3 decode shared by OP and OP-IMM
    function automatic alu_op_e funct_to_op(input logic [2:0] f3, input logic sub_en,
                                            input logic sra_en);
        case (f3)
            3'b000:  return sub_en ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sra_en ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode   = if_id_i.inst[6:0];
    assign rd       = if_id_i.inst[11:7];
    assign funct3   = if_id_i.inst[14:12];
    assign rs1      = if_id_i.inst[19:15];
    assign rs2      = if_id_i.inst[24:20];
    assign funct7_5 = if_id_i.inst[30];

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_lui    = (opcode == OPC_LUI);

    reg_file reg_file_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .wr_i     (wr_i),   // Writeback result, bypassed on match
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = if_id_i.valid && (is_op || is_op_imm || is_lui); // Else bubble
        id_ex_d.rd      = rd;
        id_ex_d.rs1     = rs1;
        id_ex_d.rs2     = rs2;
        id_ex_d.rdata1  = rdata1;
        id_ex_d.rdata2  = rdata2;
        id_ex_d.use_imm = !is_op;
        if (is_lui) begin
            id_ex_d.imm    = {if_id_i.inst[31:12], 12'b0};
            id_ex_d.alu_op = ALU_PASS_B;
        end else begin
            id_ex_d.imm    = {{20{if_id_i.inst[31]}}, if_id_i.inst[31:20]};
            id_ex_d.alu_op = funct_to_op(funct3, is_op && funct7_5, funct7_5);
        end
    end

    // ID/EX register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else if (!hold_i) begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module execute_stage (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           hold_i,
    input  rv_pkg::id_ex_t id_ex_i,
    output rv_pkg::ex_wb_t ex_wb_o
);

    import rv_pkg::*;

    logic                fwd1;
    logic                fwd2;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;

    // ==============================
    // Writeback forwarding
    // ==============================
    assign fwd1 = ex_wb_o.valid && (ex_wb_o.rd != 5'd0) && (ex_wb_o.rd == id_ex_i.rs1);
    assign fwd2 = ex_wb_o.valid && (ex_wb_o.rd != 5'd0) && (ex_wb_o.rd == id_ex_i.rs2);

    assign op_a    = fwd1 ? ex_wb_o.result : id_ex_i.rdata1;
    assign rs2_val = fwd2 ? ex_wb_o.result : id_ex_i.rdata2;
    assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;
    assign shamt   = op_b[4:0];

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // EX/WB register, also the forwarding source
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_wb_o <= '0;
        end else if (!hold_i) begin
            ex_wb_o <= '{valid: id_ex_i.valid, rd: id_ex_i.rd, result: alu_res};
        end
    end

    // Decode must only ever hand over an encoded operation
    a_alu_op_legal: assert property (@(posedge clk) disable iff (!arst_n_i)
        id_ex_i.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                               ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B});

endmodule

/* src/retire_credit.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module retire_credit (
    input  logic              clk,
    input  logic              arst_n_i,
    input  rv_pkg::ex_wb_t    ex_wb_i,
    input  logic              credit_return_i,
    output logic              retire_valid_o,
    output rv_pkg::retire_t   retire_o,
    output rv_pkg::rf_write_t wr_o,
    output logic              hold_o
);

    localparam int CNT_W = $clog2(`RV_RETIRE_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             has_credit;
    logic             fire;

    assign has_credit = (credit_cnt != '0);
    assign fire       = ex_wb_i.valid && has_credit;
    assign hold_o     = ex_wb_i.valid && !has_credit; // Stalls every stage

    assign retire_valid_o = fire;
    assign retire_o       = '{rd: ex_wb_i.rd, data: ex_wb_i.result};
    assign wr_o           = '{en: fire && (ex_wb_i.rd != 5'd0),
                              addr: ex_wb_i.rd,
                              data: ex_wb_i.result};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= CNT_W'(`RV_RETIRE_CREDITS);
        end else begin
            case ({fire, credit_return_i})
                2'b10:   credit_cnt <= credit_cnt - CNT_W'(1);
                2'b01:   credit_cnt <= credit_cnt + CNT_W'(1);
                default: credit_cnt <= credit_cnt; // Both or neither
            endcase
        end
    end

    // Receiver never returns more than it was given
    a_credit_return: assert property (@(posedge clk) disable iff (!arst_n_i)
        credit_return_i |-> (credit_cnt < `RV_RETIRE_CREDITS));

    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
        credit_cnt <= `RV_RETIRE_CREDITS);

    // At zero credits the waiting entry stays put until it can retire
    a_hold_entry: assert property (@(posedge clk) disable iff (!arst_n_i)
        hold_o |=> $stable(ex_wb_i));

endmodule

/* src/rv_pipeline_top.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_pipeline_top (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic [31:0]         inst_i,
    input  logic                credit_return_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic                retire_valid_o,
    output rv_pkg::retire_t     retire_o
);

    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb;
    rf_write_t rf_wr;
    logic      hold; // Credit back-pressure, all stages

    fetch_stage fetch_stage_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (hold),
        .inst_i   (inst_i),
        .pc_o     (pc_o),
        .if_id_o  (if_id)
    );

    decode_stage decode_stage_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (hold),
        .if_id_i  (if_id),
        .wr_i     (rf_wr),
        .id_ex_o  (id_ex)
    );

    execute_stage execute_stage_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (hold),
        .id_ex_i  (id_ex),
        .ex_wb_o  (ex_wb)
    );

    retire_credit retire_credit_inst (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .ex_wb_i         (ex_wb),
        .credit_return_i (credit_return_i),
        .retire_valid_o  (retire_valid_o),
        .retire_o        (retire_o),
        .wr_o            (rf_wr),
        .hold_o          (hold)
    );

endmodule

/* bench/tb_rv_pipeline.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_pipeline;

    import rv_pkg::*;

    logic                clk;
    logic                arst_n_i;
    logic [31:0]         inst_i;
    logic                credit_return_i;
    logic [`RV_XLEN-1:0] pc_o;
    logic                retire_valid_o;
    retire_t             retire_o;

    logic [31:0] prog [0:63];
    int          prog_len;
    retire_t     got_q [$];
    retire_t     exp_q [$];
    logic [31:0] lfsr_q;
    logic        credit_en;   // Receiver hands credits back
    int          owed;        // Retires not yet answered by a return
    int          err_cnt;
    int          err_mark;
    int          test_cnt;
    int          fail_cnt;

    rv_pipeline_top rv_pipeline_top_inst (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .inst_i          (inst_i),
        .credit_return_i (credit_return_i),
        .pc_o            (pc_o),
        .retire_valid_o  (retire_valid_o),
        .retire_o        (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic alt, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // {funct7 bit 5, funct3} for the ten register-register operations
    function automatic logic [3:0] r_op(input int k);
        case (k)
            0:       return 4'b0000; // add
            1:       return 4'b1000; // sub
            2:       return 4'b0001; // sll
            3:       return 4'b0010; // slt
            4:       return 4'b0011; // sltu
            5:       return 4'b0100; // xor
            6:       return 4'b0101; // srl
            7:       return 4'b1101; // sra
            8:       return 4'b0110; // or
            default: return 4'b0111; // and
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(input logic [`RV_XLEN-1:0] pc);
        logic [31:0] idx;
        idx = pc >> 2;
        if (idx < 32'(prog_len)) begin
            return prog[idx[5:0]];
        end
        return `RV_NOP; // Past the program
    endfunction

    task automatic add_inst(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // ==============================
    // Reference model
    // ==============================
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] w;
        logic [31:0] b;
        logic [31:0] v;
        logic        alt;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        exp_q.delete();
        for (int i = 0; i < prog_len; i++) begin
            w = prog[i];
            if (w[6:0] == 7'b0110111) begin
                v = {w[31:12], 12'h000};
            end else if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011) begin
                b   = (w[6:0] == 7'b0110011) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
                alt = w[30] && (w[6:0] == 7'b0110011 || w[14:12] == 3'b101);
                v   = ref_alu(w[14:12], alt, regs[w[19:15]], b);
            end else begin
                continue; // Never retires
            end
            exp_q.push_back('{rd: w[11:7], data: v});
            if (w[11:7] != 5'd0) begin
                regs[w[11:7]] = v;
            end
        end
    endtask

    // ==============================
    // Drivers, monitor and checks
    // ==============================
    always @(negedge clk) begin
        inst_i = fetch_word(pc_o); // Memory answers the current PC
    end

    always @(negedge clk) begin
        if (!arst_n_i) begin
            owed = 0;
            credit_return_i = 1'b0;
        end else begin
            credit_return_i = 1'b0;
            if (credit_en && owed > 0) begin
                credit_return_i = 1'b1;
                owed--;
            end
            if (retire_valid_o) begin
                got_q.push_back(retire_o);
                owed++;
            end
        end
    end

    task automatic check_retire(input int idx, input retire_t got, input retire_t exp);
        if (got !== exp) begin
            $display("ERROR retire_o[%0d]: got rd=%h data=%h, expected rd=%h data=%h",
                     idx, got.rd, got.data, exp.rd, exp.data);
            err_cnt++;
        end
    endtask

    task automatic check_pc(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERROR pc_o: got %h, expected %h", got, exp);
            err_cnt++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n_i = 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_pc(pc_o, `RV_RESET_PC);
            if (retire_valid_o) begin
                $display("retire_valid_o was high while reset was asserted");
                err_cnt++;
            end
        end
        got_q.delete();
        arst_n_i = 1'b1;
    endtask

    task automatic wait_retires(input int n);
        int t;
        t = 0;
        while (got_q.size() < n && t < 200) begin
            @(posedge clk);
            t++;
        end
        if (got_q.size() < n) begin
            $display("timed out waiting for retires, saw %0d of %0d", got_q.size(), n);
            err_cnt++;
        end
    endtask

    task automatic collect_and_compare();
        wait_retires(exp_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_retire(i, got_q[i], exp_q[i]);
        end
    endtask

    task automatic start_test();
        @(posedge clk);
        err_mark = err_cnt;
        test_cnt++;
        prog_len = 0;
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == err_mark) begin
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: FAILED with %0d errors", name, err_cnt - err_mark);
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic reset_latency();
        int  n;
        logic seen;
        start_test();
        add_inst(u_type(20'(rand_bits(20)), 5'd1));
        add_inst(i_type(12'(rand_bits(12)), 3'b000, 5'd2, 5'd1));
        add_inst(r_type(1'b0, 3'b000, 5'd3, 5'd1, 5'd2));
        run_model();
        apply_reset();
        check_pc(pc_o, `RV_RESET_PC);
        n = 0;
        seen = 1'b0;
        while (n < 10 && !seen) begin
            @(negedge clk);
            n++;
            seen = retire_valid_o;
        end
        if (!seen) begin
            $display("no retire arrived within 10 cycles of reset release");
            err_cnt++;
        end else if (n != 3) begin
            $display("first retire came %0d cycles after the fetch at PC zero, not 3", n);
            err_cnt++;
        end
        collect_and_compare();
        finish_test("reset and latency");
    endtask

    task automatic imm_and_lui();
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        start_test();
        for (int i = 0; i < 15; i++) begin
            rd = 5'(rand_bits(5));
            if (rd == 5'd0) begin
                rd = 5'd1;
            end
            if (i % 3 == 2) begin
                add_inst(u_type(20'(rand_bits(20)), rd));
            end else begin
                f3  = 3'(rand_bits(3));
                imm = 12'(rand_bits(12));
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'h00;                     // slli
                end else if (f3 == 3'b101) begin
                    imm[11:5] = {1'b0, imm[10], 5'b00000}; // srli or srai
                end
                add_inst(i_type(imm, f3, rd, 5'(rand_bits(5))));
            end
        end
        run_model();
        apply_reset();
        collect_and_compare();
        finish_test("immediate and lui");
    endtask

    task automatic dependent_ops();
        logic [4:0] rd;
        logic [4:0] p1;
        logic [4:0] p2;
        logic [3:0] op;
        start_test();
        add_inst(u_type(20'(rand_bits(20)), 5'd1));
        add_inst(i_type(12'(rand_bits(12)), 3'b000, 5'd1, 5'd1));
        add_inst(u_type(20'(rand_bits(20)), 5'd2));
        add_inst(i_type(12'(rand_bits(12)), 3'b000, 5'd2, 5'd2));
        p2 = 5'd1;
        p1 = 5'd2;
        for (int k = 0; k < 14; k++) begin
            op = r_op(k % 10);
            rd = 5'd3 + 5'(k % 8);
            // Swap ports so both forwarding muxes see the newest result
            if (k % 2 == 0) begin
                add_inst(r_type(op[3], op[2:0], rd, p1, p2));
            end else begin
                add_inst(r_type(op[3], op[2:0], rd, p2, p1));
            end
            p2 = p1;
            p1 = rd;
        end
        run_model();
        apply_reset();
        collect_and_compare();
        finish_test("register ops and forwarding");
    endtask

    task automatic credit_stall();
        logic [`RV_XLEN-1:0] held_pc;
        start_test();
        add_inst(i_type(12'(rand_bits(12)), 3'b000, 5'd1, 5'd0));
        for (int i = 0; i < 9; i++) begin
            add_inst(i_type(12'(rand_bits(12)), 3'b000, 5'd1, 5'd1));
        end
        run_model();
        credit_en = 1'b0;
        apply_reset();
        wait_retires(`RV_RETIRE_CREDITS);
        @(negedge clk);
        // Retired words plus the three held in the stage registers
        held_pc = `RV_RESET_PC + `RV_XLEN'(4 * (`RV_RETIRE_CREDITS + 3));
        for (int i = 0; i < 20; i++) begin
            if (retire_valid_o) begin
                $display("retire_valid_o rose with no credit left");
                err_cnt++;
            end
            check_pc(pc_o, held_pc);
            @(negedge clk);
        end
        if (got_q.size() != `RV_RETIRE_CREDITS) begin
            $display("saw %0d retires while credits were withheld, expected %0d",
                     got_q.size(), `RV_RETIRE_CREDITS);
            err_cnt++;
        end
        @(posedge clk);
        credit_en = 1'b1;
        collect_and_compare();
        finish_test("credit back-pressure");
    endtask

    task automatic x0_and_illegal();
        int cnt;
        start_test();
        add_inst(u_type(20'(rand_bits(20)), 5'd1));
        add_inst(i_type(12'(rand_bits(12)), 3'b000, 5'd0, 5'd1)); // Result dropped
        add_inst(r_type(1'b0, 3'b110, 5'd3, 5'd0, 5'd0));
        add_inst(32'h0010_2023);                                  // sw, unsupported
        add_inst(r_type(1'b0, 3'b000, 5'd2, 5'd0, 5'd1));
        add_inst(32'h0000_006f);                                  // jal, unsupported
        add_inst(r_type(1'b1, 3'b000, 5'd4, 5'd1, 5'd0));
        run_model();
        apply_reset();
        // Program retires fall in a window fixed by the 3 cycle latency
        repeat (2) @(negedge clk);
        cnt = 0;
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            if (retire_valid_o) begin
                cnt++;
            end
        end
        if (cnt != exp_q.size()) begin
            $display("program of %0d words retired %0d times, expected %0d",
                     prog_len, cnt, exp_q.size());
            err_cnt++;
        end
        collect_and_compare();
        finish_test("x0 and unsupported opcodes");
    endtask

    initial begin
        lfsr_q          = 32'd5;
        arst_n_i        = 1'b0;
        inst_i          = `RV_NOP;
        credit_return_i = 1'b0;
        credit_en       = 1'b1;
        owed            = 0;
        prog_len        = 0;
        err_cnt         = 0;
        err_mark        = 0;
        test_cnt        = 0;
        fail_cnt        = 0;

        reset_latency();
        imm_and_lui();
        dependent_ops();
        credit_stall();
        x0_and_illegal();

        $display("tests run %0d, tests failing %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+src
src/rv_pkg.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/retire_credit.sv
src/rv_pipeline_top.sv
bench/tb_rv_pipeline.sv

/* Bender.yml */
package:
  name: rv_pipeline

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/reg_file.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/retire_credit.sv
      - src/rv_pipeline_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_rv_pipeline.sv
